// ==== decodePkg.sv ====
package decodePkg;

    // opcode[6:2] groups, opcode[1:0] must be 2'b11
    localparam logic [4:0] LOAD    = 5'b00000;
    localparam logic [4:0] OPIMM   = 5'b00100;
    localparam logic [4:0] AUIPC   = 5'b00101;
    localparam logic [4:0] OPIMM32 = 5'b00110;
    localparam logic [4:0] STORE   = 5'b01000;
    localparam logic [4:0] OP      = 5'b01100;
    localparam logic [4:0] LUI     = 5'b01101;
    localparam logic [4:0] OP32    = 5'b01110;
    localparam logic [4:0] BRANCH  = 5'b11000;
    localparam logic [4:0] JALR    = 5'b11001;
    localparam logic [4:0] JAL     = 5'b11011;
    localparam logic [4:0] SYSTEM  = 5'b11100;

    typedef enum logic [2:0] {
        extI = 3'b000,
        extJ = 3'b001,
        extS = 3'b010,
        extB = 3'b011,
        extU = 3'b101
    } extOpT;

    typedef struct packed {
        logic [63:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        aluASrc;  // 1 = pc
        logic [1:0]  aluBSrc;  // 0 rs2, 1 const 4, 2 imm
        logic [5:0]  aluCtrl;  // [5] mul/div, [4] word op
        logic [2:0]  branch;
        logic        memRd;
        logic        memWr;
        logic        memToReg;
        logic        regWr;
        logic [2:0]  memOp;
        logic        error;
        logic        done;
    } decodedT;

endpackage

// ==== immGen.sv ====
`timescale 1ns/1ps

module immGen (
    input  logic [31:7]      instr,
    input  decodePkg::extOpT extOp,
    output logic [63:0]      imm
);
    import decodePkg::*;

    always_comb begin
        case (extOp)
            extS: begin
                imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
            end
            extB: begin
                imm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            extU: begin
                imm = {{32{instr[31]}}, instr[31:12], 12'b0};
            end
            extJ: begin
                imm = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = {{52{instr[31]}}, instr[31:20]};  // I form
            end
        endcase
    end

endmodule

// ==== ctrlDecode.sv ====
`timescale 1ns/1ps

module ctrlDecode (
    input  logic [6:0]       opcode,
    input  logic [2:0]       funct3,
    input  logic [6:0]       funct7,
    output decodePkg::extOpT extOp,
    output logic             regWr,
    output logic             aluASrc,
    output logic [1:0]       aluBSrc,
    output logic [5:0]       aluCtrl,
    output logic [2:0]       branch,
    output logic             memRd,
    output logic             memWr,
    output logic             memToReg,
    output logic [2:0]       memOp,
    output logic             error,
    output logic             done
);
    import decodePkg::*;

    logic [4:0] grp;
    logic [3:0] aluLow;
    logic       err;

    assign grp      = opcode[6:2];
    assign memOp    = funct3;
    assign memRd    = (grp == LOAD);
    assign memToReg = (grp == LOAD);
    assign memWr    = (grp == STORE);
    assign regWr    = (grp != BRANCH) && (grp != STORE) && (grp != SYSTEM);
    assign aluASrc  = (grp == AUIPC) || (grp == JAL) || (grp == JALR);
    assign done     = (grp == SYSTEM);
    assign aluCtrl[5]   = ((grp == OP) || (grp == OP32)) && funct7[0];  // M extension
    assign aluCtrl[4]   = opcode[3] & ~opcode[2];  // word forms
    assign aluCtrl[3:0] = aluLow;
    assign error = err || (opcode[1:0] != 2'b11);

    always_comb begin
        extOp   = extI;
        aluBSrc = 2'd0;
        aluLow  = 4'b0000;
        branch  = 3'b000;
        err     = 1'b0;
        case (grp)
            SYSTEM: begin
                aluBSrc = 2'd1;  // ebreak
            end
            LUI: begin
                extOp   = extU;
                aluBSrc = 2'd2;
                aluLow  = 4'b1111;  // pass b
            end
            AUIPC: begin
                extOp   = extU;
                aluBSrc = 2'd2;
            end
            JAL: begin
                extOp   = extJ;
                aluBSrc = 2'd1;
                branch  = 3'b001;
            end
            JALR: begin
                aluBSrc = 2'd1;
                branch  = 3'b010;
                err     = (funct3 != 3'b000);
            end
            BRANCH: begin
                extOp = extB;
                case (funct3)
                    3'b000: begin aluLow = 4'b0010; branch = 3'b100; end  // beq
                    3'b001: begin aluLow = 4'b0010; branch = 3'b101; end  // bne
                    3'b100: begin aluLow = 4'b0010; branch = 3'b110; end
                    3'b101: begin aluLow = 4'b0010; branch = 3'b111; end
                    3'b110: begin aluLow = 4'b0011; branch = 3'b110; end  // unsigned
                    3'b111: begin aluLow = 4'b0011; branch = 3'b111; end
                    default: err = 1'b1;
                endcase
            end
            LOAD: begin
                aluBSrc = 2'd2;
                err     = (funct3 == 3'b111);
            end
            STORE: begin
                extOp   = extS;
                aluBSrc = 2'd2;
                err     = funct3[2];
            end
            OPIMM: begin
                aluBSrc = 2'd2;
                aluLow  = {funct7[5] && (funct3 == 3'b101), funct3};
                err = ((funct3 == 3'b001) && (funct7[6:1] != 6'b000000))
                    || ((funct3 == 3'b101) && (funct7[6:1] != 6'b000000)
                        && (funct7[6:1] != 6'b010000));
            end
            OPIMM32: begin
                aluBSrc = 2'd2;
                aluLow  = {funct7[5] && (funct3 == 3'b101), funct3};
                err = (funct3 != 3'b000)
                    && ((funct3 != 3'b001) || (funct7 != 7'b0000000))
                    && ((funct3 != 3'b101) || ((funct7 != 7'b0000000)
                        && (funct7 != 7'b0100000)));
            end
            OP: begin
                aluLow = {funct7[5], funct3};
                err = (funct7 != 7'b0000000) && (funct7 != 7'b0100000)
                    && (funct7 != 7'b0000001);
            end
            OP32: begin
                aluLow = {funct7[5], funct3};
                err = ((funct7 != 7'b0000000) && (funct7 != 7'b0100000)
                        && !((funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101)))
                    && ((funct7 != 7'b0000001) || (funct3 == 3'b001)
                        || (funct3 == 3'b010) || (funct3 == 3'b011));
            end
            default: err = 1'b1;  // unknown group
        endcase
    end

endmodule

// ==== decodeLane.sv ====
`timescale 1ns/1ps

module decodeLane (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispReq,
    input  logic [31:0]        dispInstr,
    input  logic               resAck,
    output logic               dispAck,
    output logic               resReq,
    output decodePkg::decodedT resData
);
    import decodePkg::*;

    extOpT        extOp;
    wire decodedT decoded;
    logic         laneFree;
    logic         take;

    assign laneFree = !dispAck && !resReq && !resAck;  // collector fully released
    assign take     = laneFree && dispReq;

    assign decoded.rs1 = dispInstr[19:15];
    assign decoded.rs2 = dispInstr[24:20];
    assign decoded.rd  = dispInstr[11:7];

    ctrlDecode ctrl (
        .opcode(dispInstr[6:0]),
        .funct3(dispInstr[14:12]),
        .funct7(dispInstr[31:25]),
        .extOp(extOp),
        .regWr(decoded.regWr),
        .aluASrc(decoded.aluASrc),
        .aluBSrc(decoded.aluBSrc),
        .aluCtrl(decoded.aluCtrl),
        .branch(decoded.branch),
        .memRd(decoded.memRd),
        .memWr(decoded.memWr),
        .memToReg(decoded.memToReg),
        .memOp(decoded.memOp),
        .error(decoded.error),
        .done(decoded.done)
    );

    immGen immUnit (
        .instr(dispInstr[31:7]),
        .extOp(extOp),
        .imm(decoded.imm)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            dispAck <= 1'b0;
            resReq  <= 1'b0;
        end else begin
            if (take) begin
                dispAck <= 1'b1;
                resReq  <= 1'b1;
            end else if (dispAck && !dispReq) begin
                dispAck <= 1'b0;
            end
            if (resReq && resAck) begin
                resReq <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            resData <= decoded;
        end
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(dispAck) |-> $past(dispReq));
    resHeld: assert property (@(posedge clk) disable iff (rst)
        resReq |=> !resReq || $stable(resData));

endmodule

// ==== instrDispatch.sv ====
`timescale 1ns/1ps

module instrDispatch #(
    parameter int numLanes = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                instrReq,
    input  logic [31:0]         instr,
    input  logic [numLanes-1:0] dispAck,
    output logic                instrAck,
    output logic [numLanes-1:0] dispReq,
    output logic [31:0]         dispInstr
);
    localparam int ptrW = $clog2(numLanes);

    typedef enum logic [1:0] {
        stIdle,
        stReq,
        stDone
    } stateT;

    stateT           state;
    logic [ptrW-1:0] ptr;
    logic [ptrW-1:0] nextPtr;

    assign nextPtr = (ptr == ptrW'(numLanes - 1)) ? '0 : ptr + 1'b1;
    assign dispReq = (state == stReq) ? ({{(numLanes-1){1'b0}}, 1'b1} << ptr) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= stIdle;
            ptr      <= '0;
            instrAck <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (instrReq) begin
                        state <= stReq;
                    end
                end
                stReq: begin
                    if (dispAck[ptr]) begin  // lane took it
                        state    <= stDone;
                        instrAck <= 1'b1;
                    end
                end
                stDone: begin
                    if (!instrReq && !dispAck[ptr]) begin  // both sides back to zero
                        state    <= stIdle;
                        instrAck <= 1'b0;
                        ptr      <= nextPtr;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && instrReq) begin
            dispInstr <= instr;
        end
    end

    // only the addressed lane may be in a dispatch handshake
    oneLaneAtATime: assert property (@(posedge clk) disable iff (rst)
        $onehot0(dispReq | dispAck));

endmodule

// ==== resultCollect.sv ====
`timescale 1ns/1ps

module resultCollect #(
    parameter int numLanes = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [numLanes-1:0] resReq,
    input  decodePkg::decodedT  resData [numLanes],
    input  logic                outAck,
    output logic [numLanes-1:0] resAck,
    output logic                outReq,
    output decodePkg::decodedT  outData
);
    localparam int ptrW = $clog2(numLanes);

    typedef enum logic [1:0] {
        stIdle,
        stOut,
        stDrain
    } stateT;

    stateT           state;
    logic [ptrW-1:0] ptr;
    logic            ackOn;

    assign resAck = ackOn ? ({{(numLanes-1){1'b0}}, 1'b1} << ptr) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= stIdle;
            ptr    <= '0;
            ackOn  <= 1'b0;
            outReq <= 1'b0;
        end else begin
            if (ackOn && !resReq[ptr]) begin
                ackOn <= 1'b0;  // lane handshake closed
            end
            case (state)
                stIdle: begin
                    if (resReq[ptr]) begin
                        state  <= stOut;
                        ackOn  <= 1'b1;
                        outReq <= 1'b1;
                    end
                end
                stOut: begin
                    if (outAck) begin
                        state  <= stDrain;
                        outReq <= 1'b0;
                    end
                end
                stDrain: begin
                    if (!outAck && !ackOn) begin
                        state <= stIdle;
                        ptr   <= (ptr == ptrW'(numLanes - 1)) ? '0 : ptr + 1'b1;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle && resReq[ptr]) begin
            outData <= resData[ptr];
        end
    end

    outHeld: assert property (@(posedge clk) disable iff (rst) outReq |=> $stable(outData));

endmodule

// ==== decodeTop.sv ====
`timescale 1ns/1ps

module decodeTop #(
    parameter int numLanes = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        instrReq,
    input  logic [31:0] instr,
    input  logic        outAck,
    output logic        instrAck,
    output logic        outReq,
    output logic [63:0] imm,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    output logic        aluASrc,
    output logic [1:0]  aluBSrc,
    output logic [5:0]  aluCtrl,
    output logic [2:0]  branch,
    output logic        memRd,
    output logic        memWr,
    output logic        memToReg,
    output logic        regWr,
    output logic [2:0]  memOp,
    output logic        error,
    output logic        done
);
    import decodePkg::*;

    logic [numLanes-1:0] dispReq;
    logic [numLanes-1:0] dispAck;
    logic [31:0]         dispInstr;
    logic [numLanes-1:0] resReq;
    logic [numLanes-1:0] resAck;
    decodedT             resData [numLanes];
    decodedT             outData;

    instrDispatch #(.numLanes(numLanes)) dispatch (
        .clk(clk),
        .rst(rst),
        .instrReq(instrReq),
        .instr(instr),
        .dispAck(dispAck),
        .instrAck(instrAck),
        .dispReq(dispReq),
        .dispInstr(dispInstr)
    );

    for (genvar i = 0; i < numLanes; i++) begin : gLane
        decodeLane lane (
            .clk(clk),
            .rst(rst),
            .dispReq(dispReq[i]),
            .dispInstr(dispInstr),  // shared bus
            .resAck(resAck[i]),
            .dispAck(dispAck[i]),
            .resReq(resReq[i]),
            .resData(resData[i])
        );
    end

    resultCollect #(.numLanes(numLanes)) collect (
        .clk(clk),
        .rst(rst),
        .resReq(resReq),
        .resData(resData),
        .outAck(outAck),
        .resAck(resAck),
        .outReq(outReq),
        .outData(outData)
    );

    assign imm      = outData.imm;
    assign rs1      = outData.rs1;
    assign rs2      = outData.rs2;
    assign rd       = outData.rd;
    assign aluASrc  = outData.aluASrc;
    assign aluBSrc  = outData.aluBSrc;
    assign aluCtrl  = outData.aluCtrl;
    assign branch   = outData.branch;
    assign memRd    = outData.memRd;
    assign memWr    = outData.memWr;
    assign memToReg = outData.memToReg;
    assign regWr    = outData.regWr;
    assign memOp    = outData.memOp;
    assign error    = outData.error;
    assign done     = outData.done;

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock #(
    parameter int periodNs = 4
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

endmodule

// ==== tbDecode.sv ====
`timescale 1ns/1ps

module tbDecode;
    import decodePkg::*;

    localparam int lanes = 4;
    localparam logic [4:0] grpTable [12] = '{LOAD, OPIMM, AUIPC, OPIMM32, STORE, OP,
                                             LUI, OP32, BRANCH, JALR, JAL, SYSTEM};
    localparam logic [4:0] immGrp [6] = '{OPIMM, STORE, BRANCH, LUI, AUIPC, JAL};

    logic        clk;
    logic        rst;
    logic        instrReq;
    logic [31:0] instr;
    logic        outAck;
    logic        instrAck;
    logic        outReq;
    logic [63:0] imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        aluASrc;
    logic [1:0]  aluBSrc;
    logic [5:0]  aluCtrl;
    logic [2:0]  branch;
    logic        memRd;
    logic        memWr;
    logic        memToReg;
    logic        regWr;
    logic [2:0]  memOp;
    logic        error;
    logic        done;

    logic [15:0] lfsr;
    logic [31:0] words [$];
    int          delays [$];
    logic [31:0] expected [$];  // words sent and not yet seen at the output
    int          checkedCount = 0;
    int          errCount = 0;
    int          testErr = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          cycles = 0;
    int          cycleLimit = 100;

    tbClock #(.periodNs(4)) clkGen (.clk(clk));

    decodeTop #(.numLanes(lanes)) dut (
        .clk(clk), .rst(rst), .instrReq(instrReq), .instr(instr), .outAck(outAck),
        .instrAck(instrAck), .outReq(outReq), .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd),
        .aluASrc(aluASrc), .aluBSrc(aluBSrc), .aluCtrl(aluCtrl), .branch(branch),
        .memRd(memRd), .memWr(memWr), .memToReg(memToReg), .regWr(regWr),
        .memOp(memOp), .error(error), .done(done)
    );

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic takeBits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] enc(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] grp);
        return {f7, 5'd11, 5'd22, f3, 5'd5, grp, 2'b11};
    endfunction

    // expected record, straight from the opcode-group table
    function automatic decodedT refDecode(input logic [31:0] w);
        decodedT     d;
        logic [4:0]  g;
        logic [2:0]  f3;
        logic [6:0]  f7;
        g  = w[6:2];
        f3 = w[14:12];
        f7 = w[31:25];
        d  = '0;
        d.rs1        = w[19:15];
        d.rs2        = w[24:20];
        d.rd         = w[11:7];
        d.memOp      = f3;
        d.regWr      = 1'b1;
        d.imm        = {{52{w[31]}}, w[31:20]};
        d.aluCtrl[4] = (w[3:2] == 2'b10);  // word forms
        d.error      = (w[1:0] != 2'b11);
        case (g)
            LUI: begin
                d.imm = {{32{w[31]}}, w[31:12], 12'h000};
                d.aluBSrc = 2'd2;
                d.aluCtrl[3:0] = 4'b1111;
            end
            AUIPC: begin
                d.imm = {{32{w[31]}}, w[31:12], 12'h000};
                d.aluASrc = 1'b1;
                d.aluBSrc = 2'd2;
            end
            JAL: begin
                d.imm = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                d.aluASrc = 1'b1;
                d.aluBSrc = 2'd1;
                d.branch = 3'b001;
            end
            JALR: begin
                d.aluASrc = 1'b1;
                d.aluBSrc = 2'd1;
                d.branch = 3'b010;
                d.error |= (f3 != 3'd0);
            end
            BRANCH: begin
                d.imm = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                d.regWr = 1'b0;
                if (f3 inside {3'd2, 3'd3}) begin
                    d.error = 1'b1;
                end else begin
                    d.branch = {1'b1, f3[2], f3[0]};
                    d.aluCtrl[3:0] = f3[1] ? 4'b0011 : 4'b0010;  // unsigned compare
                end
            end
            LOAD: begin
                d.memRd = 1'b1;
                d.memToReg = 1'b1;
                d.aluBSrc = 2'd2;
                d.error |= (f3 == 3'd7);
            end
            STORE: begin
                d.imm = {{52{w[31]}}, w[31:25], w[11:7]};
                d.memWr = 1'b1;
                d.regWr = 1'b0;
                d.aluBSrc = 2'd2;
                d.error |= f3[2];
            end
            OPIMM, OPIMM32: begin
                d.aluBSrc = 2'd2;
                d.aluCtrl[3:0] = {(f3 == 3'd5) && f7[5], f3};
                if (g == OPIMM) begin
                    d.error |= ((f3 == 3'd1) && (f7[6:1] != 6'd0))
                        || ((f3 == 3'd5) && !(f7[6:1] inside {6'b000000, 6'b010000}));
                end else begin
                    d.error |= !((f3 == 3'd0) || ((f3 == 3'd1) && (f7 == 7'd0))
                        || ((f3 == 3'd5) && (f7 inside {7'h00, 7'h20})));
                end
            end
            OP, OP32: begin
                d.aluCtrl[3:0] = {f7[5], f3};
                d.aluCtrl[5] = f7[0];  // M extension
                if (g == OP) begin
                    d.error |= !(f7 inside {7'h00, 7'h20, 7'h01});
                end else begin
                    d.error |= !((f7 inside {7'h00, 7'h20}) || (f3 inside {3'd0, 3'd1, 3'd5})
                        || ((f7 == 7'h01) && !(f3 inside {3'd1, 3'd2, 3'd3})));
                end
            end
            SYSTEM: begin
                d.regWr = 1'b0;
                d.aluBSrc = 2'd1;
                d.done = 1'b1;
            end
            default: d.error = 1'b1;
        endcase
        return d;
    endfunction

    task automatic checkVal(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("MISMATCH at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
            errCount++;
            testErr++;
        end
    endtask

    task automatic compareResult(input decodedT exp);
        checkVal("imm", exp.imm, imm);
        checkVal("rs1", 64'(exp.rs1), 64'(rs1));
        checkVal("rs2", 64'(exp.rs2), 64'(rs2));
        checkVal("rd", 64'(exp.rd), 64'(rd));
        checkVal("aluASrc", 64'(exp.aluASrc), 64'(aluASrc));
        checkVal("aluBSrc", 64'(exp.aluBSrc), 64'(aluBSrc));
        checkVal("aluCtrl", 64'(exp.aluCtrl), 64'(aluCtrl));
        checkVal("branch", 64'(exp.branch), 64'(branch));
        checkVal("memRd", 64'(exp.memRd), 64'(memRd));
        checkVal("memWr", 64'(exp.memWr), 64'(memWr));
        checkVal("memToReg", 64'(exp.memToReg), 64'(memToReg));
        checkVal("regWr", 64'(exp.regWr), 64'(regWr));
        checkVal("memOp", 64'(exp.memOp), 64'(memOp));
        checkVal("error", 64'(exp.error), 64'(error));
        checkVal("done", 64'(exp.done), 64'(done));
    endtask

    task automatic addWord(input logic [31:0] w);
        logic [31:0] d;
        words.push_back(w);
        takeBits(3, d);  // sink delay 0..7
        delays.push_back(int'(d));
    endtask

    task automatic addCtrlWords();
        addWord(enc(7'h00, 3'd0, LUI));
        addWord(enc(7'h00, 3'd0, AUIPC));
        addWord(enc(7'h00, 3'd0, JAL));
        addWord(enc(7'h00, 3'd0, JALR));
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) addWord(enc(7'h00, 3'(f), BRANCH));
            if (f != 7) addWord(enc(7'h00, 3'(f), LOAD));
            if (f < 4) addWord(enc(7'h00, 3'(f), STORE));
            addWord(enc(7'h00, 3'(f), OPIMM));
            addWord(enc(7'h00, 3'(f), OP));
            addWord(enc(7'h01, 3'(f), OP));  // mul/div
            if (f == 0 || f >= 4) addWord(enc(7'h01, 3'(f), OP32));
            if (f == 0 || f == 1 || f == 5) begin
                addWord(enc(7'h00, 3'(f), OPIMM32));
                addWord(enc(7'h00, 3'(f), OP32));
            end
        end
        addWord(enc(7'h20, 3'd5, OPIMM));
        addWord(enc(7'h20, 3'd5, OPIMM32));
        addWord(enc(7'h20, 3'd0, OP));
        addWord(enc(7'h20, 3'd5, OP));
        addWord(enc(7'h20, 3'd0, OP32));
        addWord(enc(7'h20, 3'd5, OP32));
    endtask

    task automatic addImmWords();
        logic [31:0] r;
        logic [31:0] w;
        for (int g = 0; g < 6; g++) begin
            for (int k = 0; k < 2; k++) begin
                takeBits(25, r);
                w = {r[24:0], immGrp[g], 2'b11};
                w[31] = (k == 0);  // negative first
                if (immGrp[g] == OPIMM) w[14:12] = 3'b000;
                if (immGrp[g] == STORE) w[14] = 1'b0;
                if (immGrp[g] == BRANCH) w[13] = 1'b0;
                addWord(w);
            end
        end
    endtask

    task automatic addErrWords();
        addWord(enc(7'h00, 3'd1, JALR));
        addWord(enc(7'h00, 3'd2, BRANCH));
        addWord(enc(7'h00, 3'd7, LOAD));
        addWord(enc(7'h00, 3'd4, STORE));
        addWord(enc(7'h02, 3'd1, OPIMM));
        addWord(enc(7'h40, 3'd5, OPIMM));
        addWord(enc(7'h00, 3'd2, OPIMM32));
        addWord(enc(7'h02, 3'd0, OP));
        addWord(enc(7'h01, 3'd2, OP32));
        addWord(enc(7'h00, 3'd0, 5'b00010));  // no such group
        addWord(enc(7'h00, 3'd0, OP) & 32'hffff_fffe);  // low bits 10
        addWord(32'h0010_0073);  // ebreak
    endtask

    task automatic addBurstWords(input int n);
        logic [31:0] g;
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            takeBits(4, g);
            takeBits(25, r);
            addWord({r[24:0], grpTable[int'(g[3:0]) % 12], 2'b11});
        end
    endtask

    task automatic sendWord(input logic [31:0] w);
        instr    = w;
        instrReq = 1'b1;
        expected.push_back(w);
        do begin
            @(posedge clk);
            #1;
        end while (!instrAck);
        instrReq = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (instrAck);
    endtask

    task automatic sinkLoop();
        int waitCycles;
        forever begin
            @(posedge clk);
            #1;
            if (outReq && !outAck) begin
                if (expected.size() == 0) begin
                    $display("result at %0t ns with no word outstanding", $time);
                    errCount++;
                    testErr++;
                end else begin
                    compareResult(refDecode(expected.pop_front()));
                end
                waitCycles = delays[checkedCount % delays.size()];
                checkedCount++;
                repeat (waitCycles) begin
                    @(posedge clk);
                    #1;
                end
                outAck = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (outReq);
                outAck = 1'b0;
            end
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (testErr != 0) testsFailed++;
        $display("test %s: %s (%0d errors)", name, (testErr == 0) ? "ok" : "FAILED", testErr);
    endtask

    task automatic runTest(input string name, input int first, input int count);
        testErr = 0;
        for (int i = first; i < first + count; i++) begin
            sendWord(words[i]);
        end
        while (checkedCount < first + count) begin
            @(posedge clk);
            #1;
        end
        finishTest(name);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, only %0d of %0d words came out",
                     cycles, checkedCount, words.size());
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int ctrlFirst;
        int immFirst;
        int errFirst;
        int burstFirst;
        rst      = 1'b1;
        instrReq = 1'b0;
        instr    = '0;
        outAck   = 1'b0;
        lfsr     = 16'd93;
        ctrlFirst = words.size();
        addCtrlWords();
        immFirst = words.size();
        addImmWords();
        errFirst = words.size();
        addErrWords();
        burstFirst = words.size();
        addBurstWords(64);
        cycleLimit = words.size() * 40 + 100;

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        testErr = 0;
        repeat (4) begin  // idle, nothing offered yet
            @(posedge clk);
            #1;
            checkVal("instrAck", 64'd0, 64'(instrAck));
            checkVal("outReq", 64'd0, 64'(outReq));
        end
        finishTest("reset state");

        fork
            sinkLoop();
        join_none

        runTest("control fields", ctrlFirst, immFirst - ctrlFirst);
        runTest("immediates", immFirst, errFirst - immFirst);
        runTest("error and done", errFirst, burstFirst - errFirst);
        runTest("burst under back-pressure", burstFirst, words.size() - burstFirst);

        if (expected.size() != 0) begin
            $display("%0d words never came out", expected.size());
            errCount++;
        end
        $display("%0d tests, %0d failed, %0d words checked, %0d errors",
                 testsRun, testsFailed, checkedCount, errCount);
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
decodePkg.sv
immGen.sv
ctrlDecode.sv
decodeLane.sv
instrDispatch.sv
resultCollect.sv
decodeTop.sv
tbClock.sv
tbDecode.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tbDecode
FILELIST  := sources.f
OBJDIR    := obj_dir
SIMFLAGS  := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
PASSMSG   := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
